/* popeye_main.f */
+incdir+hdl
hdl/popeye_pkg.sv
hdl/main_decoder.sv
hdl/prog_rom.sv
hdl/work_ram.sv
hdl/prot_chip.sv
hdl/cabinet_io.sv
hdl/popeye_main.sv
testbench/tb_popeye_main.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the main board regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_popeye_main -f popeye_main.f -o sim_popeye

./obj_dir/sim_popeye > sim.log 2>&1 || true
cat sim.log

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1

/* testbench/tb_popeye_main.sv */
// Main board regression

`timescale 1ns/1ps
`default_nettype none

`include "popeye_cfg.svh"

module tb_popeye_main;
    import popeye_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int ROM_DEPTH  = `POPEYE_ROM_DEPTH;

    // Cabinet levels held for the whole run, active low
    localparam logic [4:0] JOY1    = 5'b10110;
    localparam logic [4:0] JOY2    = 5'b01001;
    localparam logic [1:0] START   = 2'b10;
    localparam logic [3:0] DIP1    = 4'b1010;
    localparam logic [7:0] DIP2    = 8'b0110_1001;

    typedef enum logic [2:0] {
        OP_MRD, OP_MWR, OP_IRD, OP_IWR, OP_FLIP, OP_VID, OP_BGW
    } op_t;

    typedef struct packed {
        op_t   op;
        logic  dma;     // Access through dma_cs, mreq idle
        addr_t addr;    // Logical address
        data_t data;
        data_t exp;     // Expected byte, bit 0 for bit checks
    } step_t;

    logic        clk;
    logic        rst_n;
    logic        cen;
    cpu_bus_t    bus;
    logic        dma_cs;
    prog_wr_t    prog;
    data_t       cpu_din;
    logic        vid_cs;
    logic        bg_wr_n;
    logic        flip;

    step_t       table_q [$];
    string       names [$];
    data_t       rom_img [ROM_DEPTH];
    logic [31:0] lfsr_state = 32'h9a2bb08b;
    int          errors = 0;
    int          checks = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          limit_cycles = 0;

    popeye_main i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .bus     (bus),
        .dma_cs  (dma_cs),
        .prog    (prog),
        .joy1    (JOY1),
        .joy2    (JOY2),
        .start   (START),
        .coin    (1'b0),
        .service (1'b1),
        .dip_sw1 (DIP1),
        .dip_sw2 (DIP2),
        .cpu_din (cpu_din),
        .vid_cs  (vid_cs),
        .bg_wr_n (bg_wr_n),
        .flip    (flip)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    //////////////////////////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////////////////////////

    // CPU pin address for a logical one, board wiring undone
    function automatic addr_t scramble(input addr_t la);
        addr_t s;
        s[2:0]   = ~la[2:0];
        s[4]     = ~la[3];
        s[5]     = ~la[4];
        s[9]     = ~la[5];
        s[3]     = la[6];
        s[6]     = la[7];
        s[7]     = la[8];
        s[8]     = la[9];
        s[15:10] = la[15:10];
        return s;
    endfunction

    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic data_t rand_byte();
        data_t b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr_step();     // One step per bit
        end
        return b;
    endfunction

    // Low byte XOR 5A, high bits folded in
    function automatic data_t fill_byte(input rom_addr_t a);
        return a[7:0] ^ 8'h5a ^ {1'b0, a[14:8]};
    endfunction

    function automatic data_t player_byte(input logic [4:0] j);
        data_t b;
        b      = 8'hff;             // Filler ones in 7..5
        b[1:0] = j[1:0];
        b[2]   = j[3];
        b[3]   = j[2];
        b[4]   = j[4];
        return b;
    endfunction

    function automatic data_t sys_byte(input logic c, input logic svc, input logic [1:0] st);
        data_t b;
        b      = 8'hff;
        b[7]   = c;
        b[6]   = svc;
        b[3:2] = st;
        return b;
    endfunction

    function automatic data_t dip_byte(input logic [2:0] col);
        data_t b;
        b      = 8'h00;
        b[3:0] = DIP1;
        b[7]   = DIP2[col];
        return b;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks and bus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_data(input string what, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0d ns: %s, got 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0d ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic set_idle();
        bus.addr   = '0;
        bus.wdata  = '0;
        bus.rd_n   = 1'b1;
        bus.wr_n   = 1'b1;
        bus.mreq_n = 1'b1;
        bus.iorq_n = 1'b1;
        dma_cs     = 1'b0;
    endtask

    task automatic drive_bus(input step_t s);
        logic is_mem;
        is_mem     = (s.op == OP_MRD) || (s.op == OP_MWR) || (s.op == OP_VID)
                     || (s.op == OP_BGW);
        bus.addr   = scramble(s.addr);
        bus.wdata  = s.data;
        bus.rd_n   = !((s.op == OP_MRD) || (s.op == OP_IRD) || (s.op == OP_VID));
        bus.wr_n   = !((s.op == OP_MWR) || (s.op == OP_IWR) || (s.op == OP_BGW));
        bus.mreq_n = !(is_mem && !s.dma);
        bus.iorq_n = !((s.op == OP_IRD) || (s.op == OP_IWR));
        dma_cs     = s.dma;
    endtask

    task automatic add_step(input op_t op, input logic dma, input addr_t addr,
                            input data_t data, input data_t exp, input string name);
        step_t s;
        s.op   = op;
        s.dma  = dma;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        table_q.push_back(s);
        names.push_back(name);
    endtask

    task automatic download_rom();
        for (int a = 0; a < ROM_DEPTH; a++) begin
            @(negedge clk);
            prog.we   = 1'b1;
            prog.addr = rom_addr_t'(a);
            prog.data = rom_img[a];
        end
        @(negedge clk);
        prog.we = 1'b0;
    endtask

    task automatic run_step(input int idx);
        step_t s;
        int    err0;
        s    = table_q[idx];
        err0 = errors;
        @(negedge clk);
        if (s.op != OP_FLIP) begin
            drive_bus(s);
        end
        case (s.op)
            OP_MRD, OP_IRD: begin
                @(negedge clk);             // Registered reads land after one edge
                check_data(names[idx], cpu_din, s.exp);
                set_idle();
            end
            OP_FLIP: begin
                check_bit(names[idx], flip, s.exp[0]);
            end
            OP_VID: begin
                @(negedge clk);
                check_bit("vid_cs on video access", vid_cs, 1'b1);
                check_data("video region read data", cpu_din, s.exp);
                set_idle();
            end
            OP_BGW: begin
                #(CLK_PERIOD / 4);
                check_bit("bg_wr_n in access cycle", bg_wr_n, 1'b0);
                @(negedge clk);
                set_idle();
                #(CLK_PERIOD / 4);
                check_bit("bg_wr_n one cycle after", bg_wr_n, 1'b0);
                @(negedge clk);
                #(CLK_PERIOD / 4);
                check_bit("bg_wr_n released", bg_wr_n, 1'b1);
            end
            default: begin                  // Plain writes
                @(negedge clk);
                set_idle();
            end
        endcase
        if (errors != err0) begin
            tests_failed++;
        end
        $display("%0d %s: %s", idx, names[idx], (errors == err0) ? "ok" : "error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table and sequence
    //////////////////////////////////////////////////////////////////////

    task automatic build_table();
        addr_t rom_addrs [9];
        rom_addrs = '{16'h0000, 16'h0155, 16'h03ff, 16'h1234, 16'h4a2c, 16'h7fff,
                      16'h0123, 16'h2a5c, 16'h7ffe};
        foreach (rom_addrs[i]) begin
            add_step(OP_MRD, 1'b0, rom_addrs[i], 8'h00, rom_img[rom_addrs[i][14:0]],
                     $sformatf("rom read 0x%04h", rom_addrs[i]));
        end
        // Work RAM and DMA
        add_step(OP_MWR, 1'b0, 16'h8123, 8'hc3, 8'h00, "ram write 0x8123");
        add_step(OP_MRD, 1'b0, 16'h8123, 8'h00, 8'hc3, "ram read 0x8123");
        add_step(OP_MRD, 1'b0, 16'h8923, 8'h00, 8'h00, "ram hole 0x8923");
        add_step(OP_MWR, 1'b1, 16'h8456, 8'h3c, 8'h00, "dma write 0x8456");
        add_step(OP_MRD, 1'b1, 16'h8456, 8'h00, 8'h3c, "dma read 0x8456");
        add_step(OP_MRD, 1'b0, 16'h8456, 8'h00, 8'h3c, "cpu read of dma byte");
        // Protection, X then Y then a count of 3
        add_step(OP_MWR, 1'b0, 16'he001, 8'hb6, 8'h00, "prot write X");
        add_step(OP_MWR, 1'b0, 16'he001, 8'h2d, 8'h00, "prot write Y");
        add_step(OP_MWR, 1'b0, 16'he000, 8'h03, 8'h00, "prot shift count");
        // 2DB6 shifted left by 3 leaves 6D on top
        add_step(OP_MRD, 1'b0, 16'he000, 8'h00, 8'h6d, "prot shift read");
        add_step(OP_MRD, 1'b0, 16'he001, 8'h00, 8'hb6 ^ 8'h2d, "prot xor read");
        // Cabinet ports
        add_step(OP_FLIP, 1'b0, 16'h0000, 8'h00, 8'h00, "flip clear after reset");
        add_step(OP_IRD, 1'b0, 16'h0000, 8'h00, dip_byte(3'd0), "dip port col 0");
        add_step(OP_IRD, 1'b0, 16'h0001, 8'h00, sys_byte(1'b0, 1'b1, START), "system port");
        add_step(OP_IRD, 1'b0, 16'h0002, 8'h00, player_byte(JOY2), "player 2 port");
        add_step(OP_IRD, 1'b0, 16'h0003, 8'h00, player_byte(JOY1), "player 1 port");
        add_step(OP_IWR, 1'b0, 16'h0000, 8'h0f, 8'h00, "io write A0 low");
        add_step(OP_FLIP, 1'b0, 16'h0000, 8'h00, 8'h00, "latch ignores A0 low");
        add_step(OP_IWR, 1'b0, 16'h0001, 8'h09, 8'h00, "latch flip, col 4");
        add_step(OP_FLIP, 1'b0, 16'h0000, 8'h00, 8'h01, "flip set");
        add_step(OP_IRD, 1'b0, 16'h0000, 8'h00, dip_byte(3'd4), "dip port col 4");
        // Video boards
        add_step(OP_VID, 1'b0, 16'ha010, 8'h00, 8'h00, "video select");
        add_step(OP_BGW, 1'b0, 16'hc020, 8'h55, 8'h00, "background strobe");
    endtask

    initial begin : watchdog
        wait (limit_cycles != 0);
        while (cycle_count < limit_cycles) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles, the regression did not finish", cycle_count);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        cen       = 1'b1;
        prog      = '0;
        set_idle();
        for (int a = 0; a < ROM_DEPTH; a++) begin
            rom_img[a] = fill_byte(rom_addr_t'(a));
        end
        rom_img[15'h0123] = rand_byte();
        rom_img[15'h2a5c] = rand_byte();
        rom_img[15'h7ffe] = rand_byte();
        build_table();
        // Download, reset and per-entry budget
        limit_cycles = ROM_DEPTH + 8 + 20 * table_q.size() + 200;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_bit("bg_wr_n idle after reset", bg_wr_n, 1'b1);
        check_bit("vid_cs idle after reset", vid_cs, 1'b0);
        download_rom();

        for (int i = 0; i < table_q.size(); i++) begin
            run_step(i);
        end

        $display("Done: %0d tests, %0d failed, %0d checks, %0d errors",
                 table_q.size(), tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/popeye_main.sv */
// Main CPU board glue

`timescale 1ns/1ps
`default_nettype none

module popeye_main (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cen,       // CPU clock enable
    input  popeye_pkg::cpu_bus_t bus,
    input  wire                  dma_cs,
    input  popeye_pkg::prog_wr_t prog,
    input  wire  [4:0]           joy1,
    input  wire  [4:0]           joy2,
    input  wire  [1:0]           start,
    input  wire                  coin,
    input  wire                  service,
    input  wire  [3:0]           dip_sw1,
    input  wire  [7:0]           dip_sw2,
    output popeye_pkg::data_t    cpu_din,
    output logic                 vid_cs,
    output logic                 bg_wr_n,
    output logic                 flip
);
    import popeye_pkg::*;

    dec_bus_t  dbus;
    chip_sel_t sel;
    data_t     rom_q;
    data_t     ram_q;
    data_t     prot_q;
    data_t     io_q;
    logic      ram_we;
    logic      prot_wr;
    logic      prot_rd;

    main_decoder u_dec (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .bus     (bus),
        .dma_cs  (dma_cs),
        .dbus    (dbus),
        .sel     (sel),
        .bg_wr_n (bg_wr_n)
    );

    assign vid_cs = sel.vid;

    prog_rom u_rom (
        .clk     (clk),
        .cen     (cen),
        .rd_addr (dbus.addr[14:0]),
        .prog    (prog),
        .q       (rom_q)
    );

    assign ram_we = sel.ram & ~dbus.wr_n;

    work_ram u_ram (
        .clk   (clk),
        .cen   (cen),
        .addr  (dbus.addr[10:0]),
        .wdata (dbus.wdata),
        .we    (ram_we),
        .q     (ram_q)
    );

    // Prot region is not mreq qualified, so keep I/O cycles out
    assign prot_wr = sel.prot & ~dbus.wr_n & ~sel.io_wr;
    assign prot_rd = sel.prot & ~dbus.rd_n & ~sel.io_rd;

    prot_chip u_prot (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .a0    (dbus.addr[0]),
        .wdata (dbus.wdata),
        .wr    (prot_wr),
        .rd    (prot_rd),
        .rdata (prot_q)
    );

    cabinet_io u_io (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .dbus    (dbus),
        .io_rd   (sel.io_rd),
        .io_wr   (sel.io_wr),
        .joy1    (joy1),
        .joy2    (joy2),
        .start   (start),
        .coin    (coin),
        .service (service),
        .dip_sw1 (dip_sw1),
        .dip_sw2 (dip_sw2),
        .rdata   (io_q),
        .flip    (flip)
    );

    //////////////////////////////////////////////////////////////////////
    // CPU data input
    //////////////////////////////////////////////////////////////////////

    // I/O first, the memory map decodes even during I/O cycles
    always_comb begin
        cpu_din = '0;                       // Video and background read as zero
        if (sel.io_rd)     cpu_din = io_q;
        else if (sel.rom)  cpu_din = rom_q;
        else if (sel.ram)  cpu_din = ram_q;
        else if (sel.prot) cpu_din = prot_q;
    end

endmodule

`default_nettype wire

/* hdl/cabinet_io.sv */
// Cabinet inputs, DIP switches and output latch

`timescale 1ns/1ps
`default_nettype none

module cabinet_io (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cen,
    input  popeye_pkg::dec_bus_t dbus,
    input  wire                  io_rd,
    input  wire                  io_wr,
    input  wire  [4:0]           joy1,      // All cabinet inputs active low
    input  wire  [4:0]           joy2,
    input  wire  [1:0]           start,
    input  wire                  coin,
    input  wire                  service,
    input  wire  [3:0]           dip_sw1,
    input  wire  [7:0]           dip_sw2,
    output popeye_pkg::data_t    rdata,
    output logic                 flip
);
    import popeye_pkg::*;

    logic [3:0] out_latch;  // Sound chip port A on the real board
    logic [2:0] dip_col;
    data_t      dip_byte;
    data_t      sys_byte;
    data_t      p1_byte;
    data_t      p2_byte;

    //////////////////////////////////////////////////////////////////////
    // Output latch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_latch <= '0;
        end else if (cen && io_wr && dbus.addr[0]) begin
            out_latch <= dbus.wdata[3:0];
        end
    end

    assign flip    = out_latch[0];
    assign dip_col = out_latch[3:1];    // DIP column for bit 7

    //////////////////////////////////////////////////////////////////////
    // Input bytes
    //////////////////////////////////////////////////////////////////////

    assign dip_byte = {dip_sw2[dip_col], 3'b000, dip_sw1};
    assign sys_byte = {coin, service, 2'b11, start, 2'b11};
    // Up and down swap places on the connector
    assign p2_byte  = {3'b111, joy2[4], joy2[2], joy2[3], joy2[1:0]};
    assign p1_byte  = {3'b111, joy1[4], joy1[2], joy1[3], joy1[1:0]};

    always_comb begin
        rdata = 8'hff;      // Open bus reads high
        if (io_rd) begin
            case (dbus.addr[1:0])
                2'd0:    rdata = dip_byte;
                2'd1:    rdata = sys_byte;
                2'd2:    rdata = p2_byte;
                default: rdata = p1_byte;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/prot_chip.sv */
// Protection chip

`timescale 1ns/1ps
`default_nettype none

module prot_chip (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               cen,
    input  wire               a0,       // Logical A0 picks the register
    input  popeye_pkg::data_t wdata,
    input  wire               wr,
    input  wire               rd,
    output popeye_pkg::data_t rdata
);
    import popeye_pkg::*;

    data_t       cur;       // Last byte written
    data_t       prev;      // The one before it
    logic [2:0]  cnt;       // Shift count
    logic [15:0] cat;
    logic [15:0] cat_sh;

    //////////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur  <= '0;
            prev <= '0;
            cnt  <= '0;
        end else if (cen && wr) begin
            if (a0) begin
                prev <= cur;        // Byte pair moves along
                cur  <= wdata;
            end else begin
                cnt <= wdata[2:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////

    assign cat    = {cur, prev};
    assign cat_sh = cat << cnt;

    always_comb begin
        rdata = '0;
        if (rd) begin
            rdata = a0 ? (prev ^ cur) : cat_sh[15:8];
        end
    end

    // CPU never reads and writes in one cycle
    a_no_rd_wr : assert property (@(posedge clk) disable iff (!rst_n)
        !(wr && rd));

endmodule

`default_nettype wire

/* hdl/work_ram.sv */
// Work RAM, 2 KB

`timescale 1ns/1ps
`default_nettype none

`include "popeye_cfg.svh"

module work_ram (
    input  wire                   clk,
    input  wire                   cen,
    input  popeye_pkg::ram_addr_t addr,
    input  popeye_pkg::data_t     wdata,
    input  wire                   we,
    output popeye_pkg::data_t     q
);
    import popeye_pkg::*;

    data_t mem [`POPEYE_RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (cen) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            q <= mem[addr];     // Old data on a write cycle
        end
    end

endmodule

`default_nettype wire

/* hdl/prog_rom.sv */
// Loadable program ROM

`timescale 1ns/1ps
`default_nettype none

`include "popeye_cfg.svh"

module prog_rom (
    input  wire                   clk,
    input  wire                   cen,
    input  popeye_pkg::rom_addr_t rd_addr,    // From logical A14..A0
    input  popeye_pkg::prog_wr_t  prog,       // Download port
    output popeye_pkg::data_t     q
);
    import popeye_pkg::*;

    data_t mem [`POPEYE_ROM_DEPTH];

    // Download runs on the full clock, independent of the CPU
    always_ff @(posedge clk) begin
        if (prog.we) begin
            mem[prog.addr] <= prog.data;
        end
    end

    // CPU side
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];  // Ready one cen later
        end
    end

endmodule

`default_nettype wire

/* hdl/main_decoder.sv */
// Address wiring and chip select decode

`timescale 1ns/1ps
`default_nettype none

module main_decoder (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cen,
    input  popeye_pkg::cpu_bus_t  bus,
    input  wire                   dma_cs,     // DMA grabs work RAM
    output popeye_pkg::dec_bus_t  dbus,
    output popeye_pkg::chip_sel_t sel,
    output logic                  bg_wr_n     // To background board
);
    import popeye_pkg::*;

    addr_t la;          // Logical address
    logic  bg_l;        // Background select, one cen late
    logic  mreq;
    logic  iorq;

    assign mreq = ~bus.mreq_n;
    assign iorq = ~bus.iorq_n;

    //////////////////////////////////////////////////////////////////////
    // Board address wiring
    //////////////////////////////////////////////////////////////////////

    assign la[2:0]   = ~bus.addr[2:0];
    assign la[3]     = ~bus.addr[4];
    assign la[4]     = ~bus.addr[5];
    assign la[5]     = ~bus.addr[9];
    assign la[6]     = bus.addr[3];          // Plain lines from here
    assign la[7]     = bus.addr[6];
    assign la[8]     = bus.addr[7];
    assign la[9]     = bus.addr[8];
    assign la[15:10] = bus.addr[15:10];      // Untouched top

    assign dbus.addr  = la;
    assign dbus.wdata = bus.wdata;
    assign dbus.rd_n  = bus.rd_n;
    assign dbus.wr_n  = bus.wr_n;

    //////////////////////////////////////////////////////////////////////
    // Memory map and I/O strobes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sel = '0;
        case (la[15:13])
            3'b100:  sel.ram  = (mreq | dma_cs) & ~la[11]; // Upper 2 KB mirror is open
            3'b101:  sel.vid  = mreq;
            3'b110:  sel.bg   = mreq;
            3'b111:  sel.prot = 1'b1;
            default: sel.rom  = 1'b1;                      // 0000-7FFF
        endcase
        sel.io_rd = iorq & ~bus.rd_n;
        sel.io_wr = iorq & ~bus.wr_n;
    end

    // Background strobe stretched by one cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bg_l <= 1'b0;
        end else if (cen) begin
            bg_l <= sel.bg;
        end
    end

    assign bg_wr_n = ~(sel.bg | bg_l);

    // Memory and I/O cycles never overlap on the Z80 bus
    a_mem_io_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(mreq && iorq));

endmodule

`default_nettype wire

/* hdl/popeye_pkg.sv */
// Main board bus types

`default_nettype none

`include "popeye_cfg.svh"

package popeye_pkg;

    typedef logic [15:0]                 addr_t;     // CPU address, raw or descrambled
    typedef logic [`POPEYE_DW-1:0]       data_t;     // One bus byte
    typedef logic [`POPEYE_ROM_AW-1:0]   rom_addr_t; // ROM index
    typedef logic [`POPEYE_RAM_AW-1:0]   ram_addr_t; // Work RAM index

    // Bus as it leaves the CPU pins, address still scrambled
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  rd_n;
        logic  wr_n;
        logic  mreq_n;
        logic  iorq_n;
    } cpu_bus_t;

    // ROM download port
    typedef struct packed {
        rom_addr_t addr;
        data_t     data;
        logic      we;
    } prog_wr_t;

    // Decoded chip selects, all active high
    typedef struct packed {
        logic rom;
        logic ram;
        logic vid;
        logic bg;
        logic prot;
        logic io_rd;
        logic io_wr;
    } chip_sel_t;

    // Bus after the board wiring
    typedef struct packed {
        addr_t addr;   // Logical address
        data_t wdata;
        logic  rd_n;
        logic  wr_n;
    } dec_bus_t;

endpackage

`default_nettype wire

/* hdl/popeye_cfg.svh */
// Main board sizes

`ifndef POPEYE_CFG_SVH
`define POPEYE_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Bus and memory widths
//////////////////////////////////////////////////////////////////////

`define POPEYE_DW       8   // Z80 data bus
`define POPEYE_ROM_AW   15  // 32 KB program space
`define POPEYE_RAM_AW   11  // 2 KB work RAM

//////////////////////////////////////////////////////////////////////
// Memory depths
//////////////////////////////////////////////////////////////////////

// Derived from the widths above
`define POPEYE_ROM_DEPTH (1 << `POPEYE_ROM_AW)
`define POPEYE_RAM_DEPTH (1 << `POPEYE_RAM_AW)

`endif
